// ==== bench/friscv_clk_gen.sv ====
//////////////////////////////
// Free running, 100 ns period, starts low
//////////////////////////////

`timescale 1ns/10ps

module friscv_clk_gen (
    output logic clk
);

    // Half period of 50 ns
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

// ==== bench/friscv_tb.sv ====
//////////////////////////////
// Program memory of 256 words from address 0
// Each of the three runs starts with reset and ends on a trap
//////////////////////////////

`timescale 1ns/10ps

module friscv_tb
    import friscv_pkg::*;
();

    logic      aclk;
    logic      rst;
    logic      imem_req;
    xlen_t     imem_addr;
    logic      imem_ack;
    inst_t     imem_data;
    status_t   status;
    xlen_t     pc_val;
    reg_addr_t dbg_addr;
    xlen_t     dbg_val;

    int        seed = 3;
    inst_t     prog [0:255];
    logic [1:0] delays [0:255];
    xlen_t     model_regs [0:31];
    trap_t     model_trap;
    xlen_t     model_pc;
    int        cycles = 0;
    int        run_start = 0;
    int        cycle_limit = 100;
    int        fetch_count = 0;
    logic      prev_req = 1'b0;

    friscv_clk_gen clk_gen (
        .clk (aclk)
    );

    friscv_core UUT (
        .aclk      (aclk),
        .rst       (rst),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .status    (status),
        .pc_val    (pc_val),
        .dbg_addr  (dbg_addr),
        .dbg_val   (dbg_val)
    );

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    //////////////////////////////
    // Memory, fetch order, timeout
    //////////////////////////////

    // Each word answers after its own stored delay
    initial begin
        int   wait_left;
        logic busy;
        imem_ack  = 1'b0;
        imem_data = '0;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge aclk);
            if (imem_ack) begin
                if (!imem_req)
                    imem_ack = 1'b0;
            end else if (imem_req) begin
                if (!busy) begin
                    wait_left = int'(delays[imem_addr[9:2]]);
                    busy      = 1'b1;
                end
                if (wait_left == 0) begin
                    imem_data = prog[imem_addr[9:2]];
                    imem_ack  = 1'b1;
                    busy      = 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    // Every new request one word above the last
    always @(negedge aclk) begin
        if (rst) begin
            fetch_count <= 0;
        end else if (imem_req && !prev_req) begin
            check_xlen("imem_addr", imem_addr, BOOT_ADDR + xlen_t'(fetch_count * 4));
            fetch_count <= fetch_count + 1;
        end
        prev_req <= imem_req;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles - run_start > cycle_limit) begin
            $display("Timeout, the run did not end within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // Program generation and model
    //////////////////////////////

    // One random OP, OP-IMM or LUI word
    function automatic inst_t random_alu_inst();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r1 = $random(seed);
        r2 = $random(seed);
        f3 = r1[14:12];
        f7 = 7'h00;
        if (r2[2] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA))
            f7 = F7_SUB_SRA;
        if (r2[1:0] == 2'd0)
            return {r1[31:12], r1[11:7], OPCODE_LUI};
        if (r2[1:0] == 2'd1)
            return {f7, r1[24:15], f3, r1[11:7], OPCODE_OP};
        // Immediate shifts keep a legal upper field
        if (f3 == F3_SLL || f3 == F3_SRL_SRA)
            return {f7, r1[24:15], f3, r1[11:7], OPCODE_OP_IMM};
        return {r1[31:15], f3, r1[11:7], OPCODE_OP_IMM};
    endfunction

    task automatic build_program(input int len, input int bad_pos, input inst_t last);
        int i;
        for (i = 0; i < 256; i++) begin
            // Filler word carries its own address
            prog[i]   = 32'hf00d_0000 | xlen_t'(i * 4);
            delays[i] = 2'($random(seed));
        end
        for (i = 0; i < len - 1; i++) begin
            prog[i] = random_alu_inst();
        end
        // Custom-0 opcode is undefined in this core
        if (bad_pos >= 0)
            prog[bad_pos] = {prog[bad_pos][31:7], 7'b0001011};
        prog[len - 1] = last;
    endtask

    function automatic xlen_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << sh;
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // Architectural run up to the first trap
    task automatic run_model();
        int    i;
        inst_t w;
        logic  alt;
        logic  f7_zero;
        logic  legal;
        xlen_t res;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_trap = TRAP_NONE;
        i = 0;
        while (model_trap == TRAP_NONE) begin
            w       = prog[i];
            alt     = (w[31:25] == F7_SUB_SRA);
            f7_zero = (w[31:25] == 7'h00);
            legal   = 1'b1;
            res     = '0;
            if (w[6:0] == OPCODE_OP) begin
                legal = f7_zero || (alt && (w[14:12] == F3_ADD_SUB || w[14:12] == F3_SRL_SRA));
                res   = ref_alu(w[14:12], alt, model_regs[w[19:15]], model_regs[w[24:20]]);
            end else if (w[6:0] == OPCODE_OP_IMM) begin
                if (w[14:12] == F3_SLL)
                    legal = f7_zero;
                if (w[14:12] == F3_SRL_SRA)
                    legal = f7_zero || alt;
                res = ref_alu(w[14:12], alt && (w[14:12] == F3_SRL_SRA),
                              model_regs[w[19:15]], {{20{w[31]}}, w[31:20]});
            end else if (w[6:0] == OPCODE_LUI) begin
                res = {w[31:12], 12'h000};
            end else if (w == INST_ECALL) begin
                model_trap = TRAP_ECALL;
            end else if (w == INST_EBREAK) begin
                model_trap = TRAP_EBREAK;
            end else begin
                legal = 1'b0;
            end
            if (!legal)
                model_trap = TRAP_ILLEGAL;
            if (model_trap == TRAP_NONE) begin
                model_regs[w[11:7]] = res;
                model_regs[0]       = '0;
            end
            i++;
        end
        // Next fetch address after the trapping word
        model_pc = BOOT_ADDR + xlen_t'(i * 4);
    endtask

    function automatic status_t status_for(input trap_t t);
        status_t s;
        s = '0;
        if (t == TRAP_ECALL)
            s[STATUS_ECALL] = 1'b1;
        if (t == TRAP_EBREAK)
            s[STATUS_EBREAK] = 1'b1;
        if (t == TRAP_ILLEGAL)
            s[STATUS_ILLEGAL] = 1'b1;
        return s;
    endfunction

    //////////////////////////////
    // Runs
    //////////////////////////////

    task automatic run_program(input int len, input int bad_pos, input inst_t last);
        int r;
        build_program(len, bad_pos, last);
        run_model();
        @(negedge aclk);
        run_start   = cycles;
        cycle_limit = len * 12 + 100;
        rst         = 1'b1;
        repeat (2) @(negedge aclk);
        rst = 1'b0;
        while (status == '0)
            @(negedge aclk);
        // A request opened on the halt edge still completes
        while (imem_req)
            @(negedge aclk);
        repeat (20) begin
            @(negedge aclk);
            check_bit("imem_req", imem_req, 1'b0);
        end
        check_status("status", status, status_for(model_trap));
        check_xlen("pc_val", pc_val, model_pc);
        for (r = 0; r < 32; r++) begin
            dbg_addr = reg_addr_t'(r);
            @(negedge aclk);
            if (r == 0)
                check_xlen("x0", dbg_val, '0);
            else
                check_xlen($sformatf("x%0d", r), dbg_val, model_regs[r]);
        end
    endtask

    initial begin
        int bad_pos;
        rst      = 1'b1;
        dbg_addr = '0;
        run_program(200, -1, INST_EBREAK);
        bad_pos = 1 + int'({$random(seed)} % 118);
        run_program(120, bad_pos, INST_EBREAK);
        run_program(60, -1, INST_ECALL);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== friscv_core.f ====
verilog/friscv_pkg.sv
verilog/friscv_inst_if.sv
verilog/friscv_registers.sv
verilog/friscv_status.sv
verilog/friscv_fetch.sv
verilog/friscv_exec.sv
verilog/friscv_core.sv
bench/friscv_clk_gen.sv
bench/friscv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the friscv_core bench with Verilator and runs it.
# The exit status is nonzero when the build or any check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    -f friscv_core.f \
    --top-module friscv_tb \
    -o friscv_sim \
    && ./obj_dir/friscv_sim \
    || exit 1

exit 0

// ==== verilog/friscv_core.sv ====
//////////////////////////////
// Four-phase req/ack instruction port, no data memory
//////////////////////////////

`timescale 1ns/10ps

module friscv_core
    import friscv_pkg::*;
(
    input  logic      aclk,
    input  logic      rst,
    output logic      imem_req,
    output xlen_t     imem_addr,
    input  logic      imem_ack,
    input  inst_t     imem_data,
    output status_t   status,
    output xlen_t     pc_val,
    input  reg_addr_t dbg_addr,
    output xlen_t     dbg_val
);

    //////////////////////////////
    // Internal signals
    //////////////////////////////

    reg_addr_t rs1_addr;
    xlen_t     rs1_val;
    reg_addr_t rs2_addr;
    xlen_t     rs2_val;
    logic      rd_wr;
    reg_addr_t rd_addr;
    xlen_t     rd_val;
    trap_t     trap;
    logic      halted;

    // Fetch to execute handshake
    friscv_inst_if inst_bus ();

    //////////////////////////////
    // Units
    //////////////////////////////

    friscv_fetch fetch (
        .aclk      (aclk),
        .rst       (rst),
        .halted    (halted),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .pc_val    (pc_val),
        .inst_bus  (inst_bus.fetch)
    );

    friscv_exec exec (
        .aclk     (aclk),
        .rst      (rst),
        .inst_bus (inst_bus.exec),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val),
        .trap     (trap)
    );

    friscv_registers isa_registers (
        .aclk     (aclk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val),
        .dbg_addr (dbg_addr),
        .dbg_val  (dbg_val)
    );

    friscv_status trap_status (
        .aclk   (aclk),
        .rst    (rst),
        .trap   (trap),
        .status (status),
        .halted (halted)
    );

endmodule

// ==== verilog/friscv_exec.sv ====
//////////////////////////////
// Single-cycle decode and ALU, no loads, stores or branches
// Any unknown encoding is reported as illegal
//////////////////////////////

`timescale 1ns/10ps

module friscv_exec
    import friscv_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,
    friscv_inst_if.exec inst_bus,
    output reg_addr_t   rs1_addr,
    input  xlen_t       rs1_val,
    output reg_addr_t   rs2_addr,
    input  xlen_t       rs2_val,
    output logic        rd_wr,
    output reg_addr_t   rd_addr,
    output xlen_t       rd_val,
    output trap_t       trap
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;
    logic       fire;
    logic       is_op;
    logic       alt;
    logic       f7_zero;
    logic       f7_ok;
    xlen_t      alu_b;
    logic [4:0] shamt;
    xlen_t      result;
    trap_t      dec_trap;

    // Field extraction
    assign opcode   = inst_bus.inst[6:0];
    assign funct3   = inst_bus.inst[14:12];
    assign funct7   = inst_bus.inst[31:25];
    assign rd_addr  = inst_bus.inst[11:7];
    assign rs1_addr = inst_bus.inst[19:15];
    assign rs2_addr = inst_bus.inst[24:20];

    assign imm_i = {{20{inst_bus.inst[31]}}, inst_bus.inst[31:20]};
    assign imm_u = {inst_bus.inst[31:12], 12'b0};

    // New instruction seen in this cycle
    assign fire = inst_bus.req && !inst_bus.ack;

    assign is_op   = (opcode == OPCODE_OP);
    assign alt     = (funct7 == F7_SUB_SRA);
    assign f7_zero = (funct7 == 7'b0);
    assign alu_b   = is_op ? rs2_val : imm_i;
    assign shamt   = alu_b[4:0];

    //////////////////////////////
    // ALU and decode
    //////////////////////////////

    always_comb begin
        result   = '0;
        dec_trap = TRAP_NONE;
        f7_ok    = 1'b1;
        case (opcode)
            OPCODE_OP, OPCODE_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        if (is_op && alt) begin
                            result = rs1_val - alu_b;
                        end else begin
                            result = rs1_val + alu_b;
                        end
                        f7_ok = !is_op || f7_zero || alt;
                    end
                    F3_SLL: begin
                        result = rs1_val << shamt;
                        f7_ok  = f7_zero;
                    end
                    F3_SRL_SRA: begin
                        if (alt) begin
                            result = $signed(rs1_val) >>> shamt;
                        end else begin
                            result = rs1_val >> shamt;
                        end
                        f7_ok = f7_zero || alt;
                    end
                    F3_SLT: begin
                        result = xlen_t'($signed(rs1_val) < $signed(alu_b));
                        f7_ok  = !is_op || f7_zero;
                    end
                    F3_SLTU: begin
                        result = xlen_t'(rs1_val < alu_b);
                        f7_ok  = !is_op || f7_zero;
                    end
                    F3_XOR: begin
                        result = rs1_val ^ alu_b;
                        f7_ok  = !is_op || f7_zero;
                    end
                    F3_OR: begin
                        result = rs1_val | alu_b;
                        f7_ok  = !is_op || f7_zero;
                    end
                    F3_AND: begin
                        result = rs1_val & alu_b;
                        f7_ok  = !is_op || f7_zero;
                    end
                endcase
                if (!f7_ok) begin
                    dec_trap = TRAP_ILLEGAL;
                end
            end
            OPCODE_LUI: begin
                result = imm_u;
            end
            OPCODE_SYSTEM: begin
                if (inst_bus.inst == INST_ECALL) begin
                    dec_trap = TRAP_ECALL;
                end else if (inst_bus.inst == INST_EBREAK) begin
                    dec_trap = TRAP_EBREAK;
                end else begin
                    dec_trap = TRAP_ILLEGAL;
                end
            end
            default: begin
                dec_trap = TRAP_ILLEGAL;
            end
        endcase
    end

    // Write and trap report share the acking edge
    assign rd_wr  = fire && (dec_trap == TRAP_NONE);
    assign rd_val = result;
    assign trap   = fire ? dec_trap : TRAP_NONE;

    always_ff @(posedge aclk) begin
        if (rst) begin
            inst_bus.ack <= 1'b0;
        end else if (fire) begin
            inst_bus.ack <= 1'b1;
        end else if (!inst_bus.req) begin
            inst_bus.ack <= 1'b0;
        end
    end

endmodule

// ==== verilog/friscv_fetch.sv ====
//////////////////////////////
// One open memory request at most, one word buffered
// After halt the PC points past the trapping instruction
//////////////////////////////

`timescale 1ns/10ps

module friscv_fetch
    import friscv_pkg::*;
(
    input  logic         aclk,
    input  logic         rst,
    input  logic         halted,
    output logic         imem_req,
    output xlen_t        imem_addr,
    input  logic         imem_ack,
    input  inst_t        imem_data,
    output xlen_t        pc_val,
    friscv_inst_if.fetch inst_bus
);

    fetch_state_t state;
    xlen_t        pc;
    logic         buf_valid;
    inst_t        buf_inst;
    xlen_t        buf_pc;
    logic         start;
    logic         capture;
    logic         load;

    // New memory request only with a free buffer
    assign start   = (state == FETCH_IDLE) && !halted && !buf_valid;
    assign capture = (state == FETCH_WAIT_ACK) && imem_ack;
    // Buffer moves to the execute handshake once the last one is closed
    assign load    = buf_valid && !inst_bus.req && !inst_bus.ack && !halted;
    assign pc_val  = pc;

    //////////////////////////////
    // Memory handshake
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= FETCH_IDLE;
            imem_req <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        imem_req <= 1'b1;
                        state    <= FETCH_WAIT_ACK;
                    end
                end
                FETCH_WAIT_ACK: begin
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        state    <= FETCH_WAIT_RELEASE;
                    end
                end
                default: begin
                    // wait for memory to drop ack
                    if (!imem_ack) begin
                        state <= FETCH_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc <= BOOT_ADDR;
        end else if (halted) begin
            pc <= inst_bus.pc + xlen_t'(ILEN / 8);
        end else if (capture) begin
            pc <= pc + xlen_t'(ILEN / 8);
        end
    end

    //////////////////////////////
    // Buffer and execute side
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            buf_valid    <= 1'b0;
            inst_bus.req <= 1'b0;
        end else begin
            if (halted) begin
                buf_valid <= 1'b0;
            end else if (capture) begin
                buf_valid <= 1'b1;
            end else if (load) begin
                buf_valid <= 1'b0;
            end
            if (inst_bus.req && inst_bus.ack) begin
                inst_bus.req <= 1'b0;
            end else if (load) begin
                inst_bus.req <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            imem_addr <= pc;
        end
        if (capture) begin
            buf_inst <= imem_data;
            buf_pc   <= imem_addr;
        end
        if (load) begin
            inst_bus.inst <= buf_inst;
            inst_bus.pc   <= buf_pc;
        end
    end

endmodule

// ==== verilog/friscv_inst_if.sv ====
//////////////////////////////
// Four-phase req/ack, payload stable while req is high
//////////////////////////////

`timescale 1ns/10ps

interface friscv_inst_if
    import friscv_pkg::*;
();

    // Request and acknowledge of the handshake
    logic  req;
    logic  ack;

    // Instruction word and its address
    inst_t inst;
    xlen_t pc;

    modport fetch (
        output req,
        output inst,
        output pc,
        input  ack
    );

    modport exec (
        input  req,
        input  inst,
        input  pc,
        output ack
    );

endinterface

// ==== verilog/friscv_pkg.sv ====
//////////////////////////////
// RV32I subset only: OP, OP-IMM, LUI and SYSTEM traps
// XLEN is fixed at 32, no compressed instructions
//////////////////////////////

package friscv_pkg;

    //////////////////////////////
    // Widths and types
    //////////////////////////////

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [7:0]      status_t;

    // First fetch address after reset
    localparam xlen_t BOOT_ADDR = '0;

    //////////////////////////////
    // Opcodes and function codes
    //////////////////////////////

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 selecting SUB and SRA/SRAI
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;

    // Only these two SYSTEM words are accepted
    localparam inst_t INST_ECALL  = 32'h0000_0073;
    localparam inst_t INST_EBREAK = 32'h0010_0073;

    //////////////////////////////
    // Status byte and enums
    //////////////////////////////

    localparam int STATUS_ECALL   = 0;
    localparam int STATUS_EBREAK  = 1;
    localparam int STATUS_ILLEGAL = 3;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_ECALL,
        TRAP_EBREAK,
        TRAP_ILLEGAL
    } trap_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT_ACK,
        FETCH_WAIT_RELEASE
    } fetch_state_t;

endpackage

// ==== verilog/friscv_registers.sv ====
//////////////////////////////
// x0 reads zero, reads are combinational
//////////////////////////////

`timescale 1ns/10ps

module friscv_registers
    import friscv_pkg::*;
(
    input  logic      aclk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    output xlen_t     rs1_val,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs2_val,
    input  logic      rd_wr,
    input  reg_addr_t rd_addr,
    input  xlen_t     rd_val,
    input  reg_addr_t dbg_addr,
    output xlen_t     dbg_val
);

    // x1 to x31, no storage for x0
    xlen_t regs [1:31];

    function automatic xlen_t read_reg(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_val;
        end
    end

    // Two execute ports and the debug port
    assign rs1_val = read_reg(rs1_addr);
    assign rs2_val = read_reg(rs2_addr);
    assign dbg_val = read_reg(dbg_addr);

endmodule

// ==== verilog/friscv_status.sv ====
//////////////////////////////
// Bits stay set until reset, any trap halts
//////////////////////////////

`timescale 1ns/10ps

module friscv_status
    import friscv_pkg::*;
(
    input  logic    aclk,
    input  logic    rst,
    input  trap_t   trap,
    output status_t status,
    output logic    halted
);

    // Bits 2 and 4 to 7 are never set here
    always_ff @(posedge aclk) begin
        if (rst) begin
            status <= '0;
            halted <= 1'b0;
        end else begin
            case (trap)
                TRAP_ECALL: begin
                    status[STATUS_ECALL] <= 1'b1;
                end
                TRAP_EBREAK: begin
                    status[STATUS_EBREAK] <= 1'b1;
                end
                TRAP_ILLEGAL: begin
                    status[STATUS_ILLEGAL] <= 1'b1;
                end
                default: begin
                    status <= status;
                end
            endcase
            // Core stops on the first trap
            if (trap != TRAP_NONE) begin
                halted <= 1'b1;
            end
        end
    end

endmodule
